// ==== common/sample_pkg.sv ====
`default_nettype none

package sample_pkg;

	//////////////////////////////
	// front-end geometry
	//////////////////////////////
	localparam int N_CH            = 16;    // adc channels
	localparam int SMP_W           = 12;    // bits per adc word
	localparam int N_GRP           = 6;     // groups per sample period
	localparam int SEL_W           = 3;
	localparam int SAMP_W          = 7;     // sample count, samp_max
	localparam int CH_FIFO_DEPTH   = 1024;
	localparam int INFO_FIFO_DEPTH = 16;    // event records

	// group index of the last group in a period
	localparam logic [SEL_W-1:0] SEL_LAST = SEL_W'(N_GRP - 1);

	// one word per channel, ch15 in the top bits
	typedef struct packed {
		logic [SMP_W-1:0] ch15, ch14, ch13, ch12;
		logic [SMP_W-1:0] ch11, ch10, ch9, ch8;
		logic [SMP_W-1:0] ch7, ch6, ch5, ch4;
		logic [SMP_W-1:0] ch3, ch2, ch1, ch0;
	} adc_group_t;

	//////////////////////////////
	// event record, 42 bits
	//////////////////////////////
	typedef struct packed {
		logic        multi_ovlp;    // two or more merged triggers
		logic        ovlp;          // at least one merged trigger
		logic [3:0]  ovlp_cnt;
		logic [11:0] l1a_mtch_cnt;
		logic [23:0] l1a_cnt;
	} l1a_info_t;

	// load controller states
	typedef enum logic {
		IDLE,
		LOAD
	} load_state_t;

endpackage

`default_nettype wire

// ==== hw/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 12,
	parameter int DEPTH = 1024
) (
	input  logic             WRCLK,
	input  logic             srst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] din,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             full,
	output logic             empty,
	output logic             overflow
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;    // words held
	logic             do_wr;
	logic             do_rd;

	// wrap at DEPTH, also for odd depths
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		if (p == AW'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full  = (count == FULL_CNT);
	assign empty = (count == '0);
	assign do_wr = wr_en & ~full;     // full drops the word
	assign do_rd = rd_en & ~empty;
	assign dout  = mem[rd_ptr];       // head word falls through

	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= wr_en & full;
			if (do_wr)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // idle or write and read together
			endcase
		end
	end

	always_ff @(posedge WRCLK) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

endmodule

`default_nettype wire

// ==== hw/l1a_tracker.sv ====
`default_nettype none

module l1a_tracker (
	input  logic                         WRCLK,
	input  logic                         srst,
	input  logic                         l1a,
	input  logic                         l1a_match,
	input  logic [sample_pkg::SEL_W-1:0] sel,
	input  logic                         busy,
	output logic                         evt_start,
	output sample_pkg::l1a_info_t        info_din,
	output logic [23:0]                  l1a_cnt,
	output logic [11:0]                  l1a_mtch_cnt
);
	import sample_pkg::*;

	logic       pending;     // matched trigger not yet started
	logic [3:0] ovlp_cnt;
	logic [3:0] ovlp_new;

	//////////////////////////////
	// trigger counters
	//////////////////////////////
	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst) begin
			l1a_cnt      <= '0;
			l1a_mtch_cnt <= '0;
		end else begin
			if (l1a)
				l1a_cnt <= l1a_cnt + 1'b1;
			if (l1a_match)
				l1a_mtch_cnt <= l1a_mtch_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// event start
	//////////////////////////////

	// release only on the last group, so loading begins at group 0
	assign evt_start = pending & (sel == SEL_LAST);

	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst)
			pending <= 1'b0;
		else
			pending <= l1a_match | (pending & ~evt_start);  // new match wins
	end

	//////////////////////////////
	// overlap tracking
	//////////////////////////////

	// count after this start; zero once the load has ended
	always_comb begin
		ovlp_new = '0;
		if (busy) begin
			if (evt_start && !(&ovlp_cnt))
				ovlp_new = ovlp_cnt + 1'b1;
			else
				ovlp_new = ovlp_cnt;    // hold, or saturated at 15
		end
	end

	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst)
			ovlp_cnt <= '0;
		else
			ovlp_cnt <= ovlp_new;
	end

	// record written to the info fifo on evt_start
	always_comb begin
		info_din.multi_ovlp   = (ovlp_new > 4'd1);
		info_din.ovlp         = (ovlp_new != 4'd0);
		info_din.ovlp_cnt     = ovlp_new;
		info_din.l1a_mtch_cnt = l1a_mtch_cnt;
		info_din.l1a_cnt      = l1a_cnt;
	end

endmodule

`default_nettype wire

// ==== fifo16ch_wide/fifo_load_fsm.sv ====
`default_nettype none

module fifo_load_fsm (
	input  logic                          WRCLK,
	input  logic                          srst,
	input  logic                          evt_start,
	input  logic [sample_pkg::SEL_W-1:0]  sel,
	input  logic [sample_pkg::SAMP_W-1:0] samp_max,
	output logic                          sinc,
	output logic                          busy
);
	import sample_pkg::*;

	load_state_t       state;
	load_state_t       state_nxt;
	logic [SAMP_W-1:0] sample;       // sample within the event
	logic [SAMP_W-1:0] sample_nxt;
	logic              period_end;

	assign period_end = (sel == SEL_LAST);

	//////////////////////////////
	// next state
	//////////////////////////////
	always_comb begin
		state_nxt  = state;
		sample_nxt = sample;
		case (state)
			IDLE: begin
				if (evt_start) begin
					state_nxt  = LOAD;
					sample_nxt = '0;
				end
			end
			LOAD: begin
				if (period_end) begin
					if (evt_start) begin
						sample_nxt = '0;    // merged trigger stretches the window
					end else if (sample == samp_max) begin
						state_nxt  = IDLE;
						sample_nxt = '0;
					end else begin
						sample_nxt = sample + 1'b1;
					end
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst) begin
			state  <= IDLE;
			sample <= '0;
		end else begin
			state  <= state_nxt;
			sample <= sample_nxt;
		end
	end

	assign busy = (state == LOAD);
	assign sinc = busy;     // all channel fifos write while loading

endmodule

`default_nettype wire

// ==== fifo16ch_wide/fifo16ch_wide.sv ====
`default_nettype none

module fifo16ch_wide (
	input  logic                          WRCLK,
	input  logic                          srst,
	input  logic                          l1a,
	input  logic                          l1a_match,
	input  sample_pkg::adc_group_t        g1_in,
	input  sample_pkg::adc_group_t        g2_in,
	input  sample_pkg::adc_group_t        g3_in,
	input  sample_pkg::adc_group_t        g4_in,
	input  sample_pkg::adc_group_t        g5_in,
	input  sample_pkg::adc_group_t        g6_in,
	input  logic [sample_pkg::SAMP_W-1:0] samp_max,
	input  logic [sample_pkg::N_CH-1:0]   rd_ena,
	input  logic                          l1a_rd_en,
	output sample_pkg::adc_group_t        dout_16ch,
	output logic [sample_pkg::N_CH-1:0]   fmt,
	output sample_pkg::l1a_info_t         l1a_smp_out,
	output logic                          rdy,
	output logic [23:0]                   l1a_cnt,
	output logic [11:0]                   l1a_mtch_cnt
);
	import sample_pkg::*;

	logic [SEL_W-1:0]           sel;
	logic [N_CH-1:0][SMP_W-1:0] mux_words;   // selected group, per channel
	logic [N_CH-1:0][SMP_W-1:0] ch_words;    // fifo head words
	logic                       evt_start;
	logic                       sinc;
	logic                       busy;
	l1a_info_t                  info_din;
	logic                       info_empty;

	//////////////////////////////
	// group selector
	//////////////////////////////
	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst)
			sel <= '0;
		else if (sel == SEL_LAST)
			sel <= '0;
		else
			sel <= sel + 1'b1;
	end

	always_comb begin
		case (sel)
			3'd0:    mux_words = g1_in;
			3'd1:    mux_words = g2_in;
			3'd2:    mux_words = g3_in;
			3'd3:    mux_words = g4_in;
			3'd4:    mux_words = g5_in;
			3'd5:    mux_words = g6_in;
			default: mux_words = '0;    // selector never gets here
		endcase
	end

	//////////////////////////////
	// control
	//////////////////////////////
	l1a_tracker i_l1a_tracker (
		.WRCLK        (WRCLK),
		.srst         (srst),
		.l1a          (l1a),
		.l1a_match    (l1a_match),
		.sel          (sel),
		.busy         (busy),
		.evt_start    (evt_start),
		.info_din     (info_din),
		.l1a_cnt      (l1a_cnt),
		.l1a_mtch_cnt (l1a_mtch_cnt)
	);

	fifo_load_fsm i_fifo_load_fsm (
		.WRCLK     (WRCLK),
		.srst      (srst),
		.evt_start (evt_start),
		.sel       (sel),
		.samp_max  (samp_max),
		.sinc      (sinc),
		.busy      (busy)
	);

	//////////////////////////////
	// channel fifos
	//////////////////////////////
	for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
		sync_fifo #(
			.WIDTH (SMP_W),
			.DEPTH (CH_FIFO_DEPTH)
		) i_ch_fifo (
			.WRCLK    (WRCLK),
			.srst     (srst),
			.wr_en    (sinc),
			.din      (mux_words[ch]),
			.rd_en    (rd_ena[ch]),
			.dout     (ch_words[ch]),
			.full     (),
			.empty    (fmt[ch]),
			.overflow ()
		);
	end

	assign dout_16ch = ch_words;

	// one record per event start
	sync_fifo #(
		.WIDTH ($bits(l1a_info_t)),
		.DEPTH (INFO_FIFO_DEPTH)
	) i_info_fifo (
		.WRCLK    (WRCLK),
		.srst     (srst),
		.wr_en    (evt_start),
		.din      (info_din),
		.rd_en    (l1a_rd_en),
		.dout     (l1a_smp_out),
		.full     (),
		.empty    (info_empty),
		.overflow ()
	);

	assign rdy = ~info_empty;

endmodule

`default_nettype wire

// ==== verif/tb_fifo16ch_wide.sv ====
`default_nettype none

module tb_fifo16ch_wide;
	timeunit 1ns;
	timeprecision 100ps;

	import sample_pkg::*;

	localparam int WAIT_MAX = 4000;    // cycles per wait loop

	logic                       WRCLK = 1'b0;
	logic                       srst;
	logic                       l1a;
	logic                       l1a_match;
	adc_group_t                 grp_in [N_GRP] = '{default: '0};
	logic [SAMP_W-1:0]          samp_max;
	logic [N_CH-1:0]            rd_ena;
	logic                       l1a_rd_en;
	adc_group_t                 dout_16ch;
	logic [N_CH-1:0]            fmt;
	l1a_info_t                  l1a_smp_out;
	logic                       rdy;
	logic [23:0]                l1a_cnt;
	logic [11:0]                l1a_mtch_cnt;
	logic [N_CH-1:0][SMP_W-1:0] dout_words;    // head word per channel

	int    cyc = 0;      // running cycle number
	int    rst_cyc;      // cycle in which srst fell, sel is 0 there
	int    errors = 0;
	int    timeouts = 0;
	int    n_l1a;
	int    n_mtch;
	int    wr_q [$];     // cycles whose words land in the channel fifos
	string test_name;

	fifo16ch_wide i_fifo16ch_wide (
		.WRCLK        (WRCLK),
		.srst         (srst),
		.l1a          (l1a),
		.l1a_match    (l1a_match),
		.g1_in        (grp_in[0]),
		.g2_in        (grp_in[1]),
		.g3_in        (grp_in[2]),
		.g4_in        (grp_in[3]),
		.g5_in        (grp_in[4]),
		.g6_in        (grp_in[5]),
		.samp_max     (samp_max),
		.rd_ena       (rd_ena),
		.l1a_rd_en    (l1a_rd_en),
		.dout_16ch    (dout_16ch),
		.fmt          (fmt),
		.l1a_smp_out  (l1a_smp_out),
		.rdy          (rdy),
		.l1a_cnt      (l1a_cnt),
		.l1a_mtch_cnt (l1a_mtch_cnt)
	);

	assign dout_words = dout_16ch;

	always #4 WRCLK = ~WRCLK;

	always @(posedge WRCLK) cyc <= cyc + 1;

	//////////////////////////////
	// adc word model
	//////////////////////////////
	function automatic logic [SMP_W-1:0] word_val(input int k, input int g, input int ch);
		return SMP_W'(k * 53 + g * 389 + ch * 97 + (k >> 4) * 11);
	endfunction

	function automatic adc_group_t make_group(input int k, input int g);
		logic [N_CH-1:0][SMP_W-1:0] w;
		for (int ch = 0; ch < N_CH; ch++)
			w[ch] = word_val(k, g, ch);
		return adc_group_t'(w);
	endfunction

	// every group changes every cycle
	always @(posedge WRCLK) begin
		#1;
		for (int g = 0; g < N_GRP; g++)
			grp_in[g] = make_group(cyc, g);
	end

	function automatic int sel_of(input int k);
		return (k - rst_cyc) % N_GRP;
	endfunction

	// first cycle after t with sel on the last group
	function automatic int next_start(input int t);
		int k;
		k = t + 1;
		while (sel_of(k) != N_GRP - 1)
			k++;
		return k;
	endfunction

	function automatic void add_writes(input int first, input int last);
		for (int k = first; k <= last; k++)
			wr_q.push_back(k);
	endfunction

	function automatic logic [SMP_W-1:0] exp_word(input int idx, input int ch);
		return word_val(wr_q[idx], sel_of(wr_q[idx]), ch);
	endfunction

	//////////////////////////////
	// helpers
	//////////////////////////////
	task automatic tick();
		@(posedge WRCLK);
		#1;
	endtask

	task automatic report_mismatch(input string what, input logic [63:0] exp,
			input logic [63:0] act);
		errors++;
		$display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
	endtask

	task automatic reset_dut();
		srst      = 1'b1;
		l1a       = 1'b0;
		l1a_match = 1'b0;
		rd_ena    = '0;
		l1a_rd_en = 1'b0;
		repeat (4) tick();
		srst    = 1'b0;
		rst_cyc = cyc;
		n_l1a   = 0;
		n_mtch  = 0;
		wr_q.delete();
	endtask

	task automatic pulse_trig(input logic match, output int t);
		l1a       = 1'b1;
		l1a_match = match;
		t         = cyc;
		n_l1a++;
		if (match)
			n_mtch++;
		tick();
		l1a       = 1'b0;
		l1a_match = 1'b0;
	endtask

	task automatic wait_cycle(input int target, output bit ok);
		int n;
		n = 0;
		while (cyc < target && n < WAIT_MAX) begin
			tick();
			n++;
		end
		ok = (cyc >= target);
		if (!ok) begin
			timeouts++;
			$display("%s: gave up waiting for cycle %0d", test_name, target);
		end
	endtask

	task automatic wait_rdy(output bit ok);
		int n;
		n = 0;
		while (rdy !== 1'b1 && n < WAIT_MAX) begin
			tick();
			n++;
		end
		ok = (rdy === 1'b1);
		if (!ok) begin
			timeouts++;
			$display("%s: no event record showed up in the info fifo", test_name);
		end
	endtask

	task automatic check_and_pop_record(input int c, input int m, input int oc);
		l1a_info_t exp;
		exp.multi_ovlp   = (oc > 1);
		exp.ovlp         = (oc > 0);
		exp.ovlp_cnt     = 4'(oc);
		exp.l1a_mtch_cnt = 12'(m);
		exp.l1a_cnt      = 24'(c);
		if (l1a_smp_out !== exp)
			report_mismatch("event record", 64'(exp), 64'(l1a_smp_out));
		l1a_rd_en = 1'b1;
		tick();
		l1a_rd_en = 1'b0;
	endtask

	// pop n words from all channels at once, then all must be empty
	task automatic read_all(input int n);
		rd_ena = '1;
		for (int i = 0; i < n; i++) begin
			if (fmt !== '0) begin
				errors++;
				$display("%s: channel fifos ran empty after %0d of %0d words", test_name, i, n);
				break;
			end
			for (int ch = 0; ch < N_CH; ch++) begin
				if (dout_words[ch] !== exp_word(i, ch))
					report_mismatch($sformatf("ch%0d word %0d", ch, i),
						64'(exp_word(i, ch)), 64'(dout_words[ch]));
			end
			tick();
		end
		rd_ena = '0;
		if (fmt !== '1)
			report_mismatch("empty flags after read", 64'({N_CH{1'b1}}), 64'(fmt));
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic test_reset();
		test_name = "reset";
		reset_dut();
		if (fmt !== '1)
			report_mismatch("fmt", 64'({N_CH{1'b1}}), 64'(fmt));
		if (rdy !== 1'b0)
			report_mismatch("rdy", 64'(0), 64'(rdy));
		if (l1a_cnt !== '0)
			report_mismatch("l1a_cnt", 64'(0), 64'(l1a_cnt));
		if (l1a_mtch_cnt !== '0)
			report_mismatch("l1a_mtch_cnt", 64'(0), 64'(l1a_mtch_cnt));
	endtask

	task automatic test_single_event();
		int t;
		int u;
		bit ok;
		test_name = "single_event";
		reset_dut();
		samp_max = 7'd2;
		tick();
		tick();
		pulse_trig(1'b1, t);
		u = next_start(t);
		add_writes(u + 1, u + 18);     // three full periods
		wait_rdy(ok);
		if (!ok)
			return;
		if (cyc != u + 1)
			report_mismatch("record cycle", 64'(u + 1), 64'(cyc));
		check_and_pop_record(n_l1a, n_mtch, 0);
		if (rdy !== 1'b0)
			report_mismatch("rdy after pop", 64'(0), 64'(rdy));
		wait_cycle(u + 19, ok);
		if (!ok)
			return;
		read_all(18);
	endtask

	task automatic test_counters();
		test_name = "counters";
		reset_dut();
		samp_max = 7'd0;
		for (int i = 0; i < 60; i++) begin
			l1a       = 1'($urandom_range(1, 0));
			l1a_match = l1a & 1'($urandom_range(1, 0));
			if (l1a)
				n_l1a++;
			if (l1a_match)
				n_mtch++;
			tick();
		end
		l1a       = 1'b0;
		l1a_match = 1'b0;
		tick();                        // last pulse lands here
		if (l1a_cnt !== 24'(n_l1a))
			report_mismatch("l1a_cnt", 64'(n_l1a), 64'(l1a_cnt));
		if (l1a_mtch_cnt !== 12'(n_mtch))
			report_mismatch("l1a_mtch_cnt", 64'(n_mtch), 64'(l1a_mtch_cnt));
	endtask

	task automatic test_overlap();
		int t0;
		int t1;
		int t2;
		int u1;
		int u2;
		bit ok;
		test_name = "overlap";
		reset_dut();
		samp_max = 7'd3;
		tick();
		pulse_trig(1'b1, t1);
		u1 = next_start(t1);
		wait_rdy(ok);
		if (!ok)
			return;
		check_and_pop_record(n_l1a, n_mtch, 0);
		pulse_trig(1'b0, t0);          // unmatched, counted only
		wait_cycle(u1 + 7, ok);        // inside the second period
		if (!ok)
			return;
		pulse_trig(1'b1, t2);
		u2 = next_start(t2);
		add_writes(u1 + 1, u2 + 24);   // window restarts at u2
		wait_rdy(ok);
		if (!ok)
			return;
		if (cyc != u2 + 1)
			report_mismatch("second record cycle", 64'(u2 + 1), 64'(cyc));
		check_and_pop_record(n_l1a, n_mtch, 1);
		wait_cycle(u2 + 25, ok);
		if (!ok)
			return;
		read_all(6 * ((u2 - u1) / 6 + 4));
	endtask

	task automatic test_overflow();
		int t;
		int u;
		bit ok;
		test_name = "overflow";
		reset_dut();
		samp_max = 7'd127;
		for (int ev = 0; ev < 2; ev++) begin
			pulse_trig(1'b1, t);
			u = next_start(t);
			add_writes(u + 1, u + 768);
			wait_cycle(u + 769, ok);
			if (!ok)
				return;
		end
		read_all(CH_FIFO_DEPTH);       // the rest was dropped
	endtask

	task automatic test_channel_order();
		int t;
		int u;
		bit ok;
		logic [N_CH-1:0] exp_fmt;
		test_name = "channel_order";
		reset_dut();
		samp_max = 7'd0;
		pulse_trig(1'b1, t);
		u = next_start(t);
		add_writes(u + 1, u + 6);
		wait_cycle(u + 7, ok);
		if (!ok)
			return;
		for (int ch = 0; ch < N_CH; ch++) begin
			for (int i = 0; i < N_GRP; i++) begin
				if (fmt[ch] !== 1'b0) begin
					errors++;
					$display("%s: ch%0d empty before word %0d", test_name, ch, i);
					break;
				end
				if (dout_words[ch] !== exp_word(i, ch))
					report_mismatch($sformatf("ch%0d word %0d", ch, i),
						64'(exp_word(i, ch)), 64'(dout_words[ch]));
				rd_ena = N_CH'(1) << ch;
				tick();
			end
			rd_ena = '0;
			for (int j = 0; j < N_CH; j++)
				exp_fmt[j] = (j <= ch);
			if (fmt !== exp_fmt)
				report_mismatch($sformatf("fmt after ch%0d", ch), 64'(exp_fmt), 64'(fmt));
			for (int j = ch + 1; j < N_CH; j++) begin
				if (dout_words[j] !== exp_word(0, j))    // untouched head
					report_mismatch($sformatf("ch%0d head", j),
						64'(exp_word(0, j)), 64'(dout_words[j]));
			end
		end
	endtask

	initial begin
		srst      = 1'b1;
		l1a       = 1'b0;
		l1a_match = 1'b0;
		samp_max  = '0;
		rd_ena    = '0;
		l1a_rd_en = 1'b0;
		void'($urandom(32'h539b));
		test_reset();
		test_single_event();
		test_counters();
		test_overlap();
		test_overflow();
		test_channel_order();
		tick();
		$display("summary: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
common/sample_pkg.sv
hw/sync_fifo.sv
hw/l1a_tracker.sv
fifo16ch_wide/fifo_load_fsm.sv
fifo16ch_wide/fifo16ch_wide.sv
verif/tb_fifo16ch_wide.sv

// ==== Makefile ====
TOP  := tb_fifo16ch_wide
SRCS := $(shell cat sim.f)

all: run

obj_dir/V$(TOP): $(SRCS) sim.f
	verilator --binary --timing -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
